/* common/ising_config.svh */
// ====================
// Array size of the spin solver
// Write address map
// Widths of weights, row sums, energy and sweep count
// ====================
`ifndef ISING_CONFIG_SVH
`define ISING_CONFIG_SVH

// Number of spins
`define ISING_N 4
// One weight per spin pair
`define ISING_NUM_PAIRS (`ISING_N * (`ISING_N - 1) / 2)

// Control word and first weight, byte addresses
`define ISING_CTRL_ADDR 32'h0
`define ISING_WEIGHT_ADDR_BASE 32'h100

// Field widths
`define ISING_WEIGHT_W 3
`define ISING_FIELD_W 6
`define ISING_ENERGY_W 8
`define ISING_SWEEP_W 8

`endif

/* common/ising_pkg.sv */
// ====================
// Spin, weight, field, energy and sweep types
// Write word union with weight and control views
// Result struct
// Triangular pair index function
// ====================
`include "ising_config.svh"

package ising_pkg;

    // Bit set means +1, clear means -1
    typedef logic [`ISING_N-1:0] spin_vec_t;
    // Coupling, -4 to +3
    typedef logic signed [`ISING_WEIGHT_W-1:0] weight_t;
    typedef logic signed [`ISING_FIELD_W-1:0] field_t;
    typedef logic signed [`ISING_ENERGY_W-1:0] energy_t;
    typedef logic [`ISING_SWEEP_W-1:0] sweep_t;

    // Pair order (0,1) (0,2) .. (0,N-1) (1,2) .. (N-2,N-1)
    typedef weight_t [`ISING_NUM_PAIRS-1:0] weight_arr_t;

    // wdata seen as a weight write
    typedef struct packed {
        logic [31-`ISING_WEIGHT_W:0] rsvd;
        weight_t                     weight;
    } weight_view_t;

    // wdata seen as the control word
    typedef struct packed {
        logic [15:0] rsvd_hi;
        sweep_t      sweeps;
        spin_vec_t   init_spins;
        logic [2:0]  rsvd_lo;
        logic        start;
    } ctrl_view_t;

    typedef union packed {
        weight_view_t wgt;
        ctrl_view_t   ctrl;
    } cfg_word_u;

    // Handed out over req/ack
    typedef struct packed {
        spin_vec_t spins;
        energy_t   energy;
        sweep_t    sweeps;
    } result_t;

    // Index of weight (i,j), i<j
    function automatic int pair_idx(input int n, input int i, input int j);
        return n * i - i * (i + 1) / 2 + j - i - 1;
    endfunction

endpackage

/* core/coupled_cell.sv */
// ====================
// Off-diagonal cell
// Adds +/- weight to the passing row sum
// ====================
`timescale 1ns/100ps

module coupled_cell (
    input  logic               clk,
    input  logic               rst_n,
    input  ising_pkg::field_t  sum_in,
    input  logic               spin_in,
    input  ising_pkg::weight_t weight,
    output ising_pkg::field_t  sum_out
);
    import ising_pkg::*;

    field_t w_ext;

    // Coupling widened to row sum width
    assign w_ext = field_t'(weight);

    // One register per cell, stands in for the wire delay
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_out <= '0;
        end else if (spin_in) begin
            // Spin +1
            sum_out <= sum_in + w_ext;
        end else begin
            // Spin -1
            sum_out <= sum_in - w_ext;
        end
    end

endmodule

/* core/spin_cell.sv */
// ====================
// Diagonal cell
// Spin state, sign rule update
// Row sum restart
// ====================
`timescale 1ns/100ps

module spin_cell (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load,
    input  logic              load_spin,
    input  logic              update,
    input  ising_pkg::field_t sum_in,
    output logic              spin,
    output ising_pkg::field_t sum_out
);
    logic restart;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            spin    <= 1'b0;
            restart <= 1'b0;
        end else begin
            // New pass follows a load or an update
            restart <= load || update;
            if (load) begin
                spin <= load_spin;
            end else if (update) begin
                // Zero field keeps the spin
                if (sum_in > 0) begin
                    spin <= 1'b1;
                end else if (sum_in < 0) begin
                    spin <= 1'b0;
                end
            end
        end
    end

    // Ring closes here, zero injected at pass start
    assign sum_out = restart ? '0 : sum_in;

endmodule

/* core/core_matrix.sv */
// ====================
// NxN grid of spin and coupled cells
// Phase and sweep counters
// Done pulse and busy flag
// ====================
`timescale 1ns/100ps

`include "ising_config.svh"

module core_matrix #(
    parameter int N = `ISING_N
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  ising_pkg::spin_vec_t            init_spins,
    input  ising_pkg::sweep_t               sweeps,
    input  ising_pkg::weight_t [N*(N-1)/2-1:0] weights,
    output logic                            done,
    output logic                            core_busy,
    output ising_pkg::spin_vec_t            spins,
    output ising_pkg::sweep_t               sweeps_used
);
    import ising_pkg::*;

    localparam int PH_W = $clog2(N);

    logic [PH_W-1:0] phase;
    sweep_t          sweeps_left;
    logic            running;
    logic            zero_done;
    logic            update;
    // row_sum[r][p] leaves position p of row r, position 0 is the spin cell
    field_t          row_sum [N][N];

    // Last phase of a sweep, every spin cell updates
    assign update    = running && (phase == PH_W'(N - 1));
    assign done      = (update && sweeps_left == sweep_t'(1)) || zero_done;
    assign core_busy = running || zero_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running     <= 1'b0;
            zero_done   <= 1'b0;
            phase       <= '0;
            sweeps_left <= '0;
        end else begin
            // Zero sweeps, finish straight away
            zero_done <= start && (sweeps == '0);
            if (start) begin
                running     <= (sweeps != '0);
                phase       <= '0;
                sweeps_left <= sweeps;
            end else if (update) begin
                phase       <= '0;
                sweeps_left <= sweeps_left - 1'b1;
                if (sweeps_left == sweep_t'(1)) begin
                    running <= 1'b0;
                end
            end else if (running) begin
                phase <= phase + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sweeps_used <= sweeps;
        end
    end

    genvar i, j;
    generate
        // Diagonal, one per spin
        for (i = 0; i < N; i++) begin : g_diag
            spin_cell i_spin (
                .clk       (clk),
                .rst_n     (rst_n),
                .load      (start),
                .load_spin (init_spins[i]),
                .update    (update),
                .sum_in    (row_sum[i][N-1]),
                .spin      (spins[i]),
                .sum_out   (row_sum[i][0])
            );
        end

        // Position p of row r couples to spin (r+p) mod N
        for (i = 0; i < N; i++) begin : g_row
            for (j = i + 1; j < N; j++) begin : g_pair
                localparam int K = pair_idx(N, i, j);

                // Right half, row i sees spin j
                coupled_cell i_right (
                    .clk     (clk),
                    .rst_n   (rst_n),
                    .sum_in  (row_sum[i][j-i-1]),
                    .spin_in (spins[j]),
                    .weight  (weights[K]),
                    .sum_out (row_sum[i][j-i])
                );

                // Left half, row j sees spin i
                coupled_cell i_left (
                    .clk     (clk),
                    .rst_n   (rst_n),
                    .sum_in  (row_sum[j][N-(j-i)-1]),
                    .spin_in (spins[i]),
                    .weight  (weights[K]),
                    .sum_out (row_sum[j][N-(j-i)])
                );
            end
        end
    endgenerate

endmodule

/* design/weight_regs.sv */
// ====================
// Write strobe decode
// Triangular weight store
// Control word latch and start pulse
// ====================
`timescale 1ns/100ps

`include "ising_config.svh"

module weight_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wready,
    input  logic [31:0]            wr_addr,
    input  logic [31:0]            wdata,
    input  logic                   core_busy,
    input  logic                   rd_busy,
    output logic                   start,
    output ising_pkg::spin_vec_t   init_spins,
    output ising_pkg::sweep_t      sweeps,
    output ising_pkg::weight_arr_t weights
);
    import ising_pkg::*;

    localparam int NP = `ISING_NUM_PAIRS;

    cfg_word_u     cfg;
    logic          wr_ok;
    logic [NP-1:0] wgt_hit;
    logic          ctrl_hit;

    assign cfg = wdata;

    // Locked while a run, a pending result or the start pulse is in flight
    assign wr_ok = wready && !core_busy && !rd_busy && !start;

    // One address compare per pair
    genvar i, j;
    generate
        for (i = 0; i < `ISING_N; i++) begin : g_row
            for (j = i + 1; j < `ISING_N; j++) begin : g_pair
                localparam int K = pair_idx(`ISING_N, i, j);
                assign wgt_hit[K] = (wr_addr == `ISING_WEIGHT_ADDR_BASE + 32'(4 * K));
            end
        end
    endgenerate

    // Control write only counts with start set
    assign ctrl_hit = wr_ok && (wr_addr == `ISING_CTRL_ADDR) && cfg.ctrl.start;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start   <= 1'b0;
            weights <= '0;
        end else begin
            start <= ctrl_hit;
            for (int k = 0; k < NP; k++) begin
                if (wr_ok && wgt_hit[k]) begin
                    weights[k] <= cfg.wgt.weight;
                end
            end
        end
    end

    // Run parameters, taken with the start write
    always_ff @(posedge clk) begin
        if (ctrl_hit) begin
            init_spins <= cfg.ctrl.init_spins;
            sweeps     <= cfg.ctrl.sweeps;
        end
    end

endmodule

/* design/readout.sv */
// ====================
// Energy of the final spins, one pair per cycle
// Result register
// Four-phase req/ack FSM
// ====================
`timescale 1ns/100ps

`include "ising_config.svh"

module readout (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   done,
    input  ising_pkg::spin_vec_t   spins,
    input  ising_pkg::sweep_t      sweeps_used,
    input  ising_pkg::weight_arr_t weights,
    input  logic                   res_ack,
    output logic                   res_req,
    output ising_pkg::result_t     res,
    output logic                   rd_busy
);
    import ising_pkg::*;

    localparam int NP    = `ISING_NUM_PAIRS;
    localparam int IDX_W = $clog2(`ISING_N);
    localparam int K_W   = $clog2(NP);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CALC,
        ST_REQ,
        ST_ACK_LOW
    } state_t;

    state_t           state;
    logic [IDX_W-1:0] pi;
    logic [IDX_W-1:0] pj;
    logic [K_W-1:0]   k;
    energy_t          acc;
    energy_t          acc_next;
    weight_t          w_cur;
    logic             last_pair;

    // Pairs walked in weight order, so k is the weight index
    assign w_cur     = weights[k];
    assign last_pair = (k == K_W'(NP - 1));

    // Aligned pair lowers the energy by J, opposed pair raises it
    assign acc_next = (spins[pi] == spins[pj]) ? acc - energy_t'(w_cur)
                                               : acc + energy_t'(w_cur);

    assign res_req = (state == ST_REQ);
    // Blocks new runs until ack has dropped
    assign rd_busy = (state != ST_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            pi    <= '0;
            pj    <= '0;
            k     <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (done) begin
                        state <= ST_CALC;
                        pi    <= '0;
                        pj    <= IDX_W'(1);
                        k     <= '0;
                    end
                end
                ST_CALC: begin
                    k <= k + 1'b1;
                    // End of a row, next row starts right of the diagonal
                    if (pj == IDX_W'(`ISING_N - 1)) begin
                        pi <= pi + 1'b1;
                        pj <= pi + IDX_W'(2);
                    end else begin
                        pj <= pj + 1'b1;
                    end
                    if (last_pair) begin
                        state <= ST_REQ;
                    end
                end
                // Hold req and result until ack
                ST_REQ: begin
                    if (res_ack) begin
                        state <= ST_ACK_LOW;
                    end
                end
                ST_ACK_LOW: begin
                    if (!res_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Accumulator and result payload
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && done) begin
            acc <= '0;
        end else if (state == ST_CALC) begin
            acc <= acc_next;
            if (last_pair) begin
                res.spins  <= spins;
                res.energy <= acc_next;
                res.sweeps <= sweeps_used;
            end
        end
    end

endmodule

/* design/ising_top.sv */
// ====================
// Spin solver top
// Write decode, core array, readout
// ====================
`timescale 1ns/100ps

module ising_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wready,
    input  logic [31:0]          wr_addr,
    input  logic [31:0]          wdata,
    input  logic                 res_ack,
    output logic                 res_req,
    output ising_pkg::result_t   res,
    output ising_pkg::spin_vec_t spins
);
    import ising_pkg::*;

    logic        start;
    logic        done;
    logic        core_busy;
    logic        rd_busy;
    spin_vec_t   init_spins;
    sweep_t      sweeps;
    sweep_t      sweeps_used;
    weight_arr_t weights;

    // Write side, weights and control word
    weight_regs i_weight_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .wready     (wready),
        .wr_addr    (wr_addr),
        .wdata      (wdata),
        .core_busy  (core_busy),
        .rd_busy    (rd_busy),
        .start      (start),
        .init_spins (init_spins),
        .sweeps     (sweeps),
        .weights    (weights)
    );

    core_matrix i_core_matrix (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .init_spins  (init_spins),
        .sweeps      (sweeps),
        .weights     (weights),
        .done        (done),
        .core_busy   (core_busy),
        .spins       (spins),
        .sweeps_used (sweeps_used)
    );

    // Energy and handshake out
    readout i_readout (
        .clk         (clk),
        .rst_n       (rst_n),
        .done        (done),
        .spins       (spins),
        .sweeps_used (sweeps_used),
        .weights     (weights),
        .res_ack     (res_ack),
        .res_req     (res_req),
        .res         (res),
        .rd_busy     (rd_busy)
    );

endmodule

/* verif/ising_tb_model.svh */
// ====================
// Testbench reference model
// Coupling table, Jacobi sweep, energy
// Fibonacci LFSR random source
// ====================
`ifndef ISING_TB_MODEL_SVH
`define ISING_TB_MODEL_SVH

`include "ising_config.svh"

// Symmetric couplings as written to the DUT
int          mw [`ISING_N][`ISING_N];
// Random source state
logic [31:0] lfsr;

// Taps for x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
        v[b] = lfsr_bit();
    end
    return v;
endfunction

// All spins from the old vector, updated together
function automatic logic [`ISING_N-1:0] model_sweep(input logic [`ISING_N-1:0] s);
    logic [`ISING_N-1:0] ns;
    int                  f;
    ns = s;
    for (int i = 0; i < `ISING_N; i++) begin
        f = 0;
        for (int j = 0; j < `ISING_N; j++) begin
            if (j != i) begin
                f = s[j] ? f + mw[i][j] : f - mw[i][j];
            end
        end
        // Zero field keeps the spin
        if (f > 0) begin
            ns[i] = 1'b1;
        end else if (f < 0) begin
            ns[i] = 1'b0;
        end
    end
    return ns;
endfunction

function automatic logic [`ISING_N-1:0] model_run(input logic [`ISING_N-1:0] s,
                                                  input int sweeps);
    logic [`ISING_N-1:0] cur;
    cur = s;
    for (int k = 0; k < sweeps; k++) begin
        cur = model_sweep(cur);
    end
    return cur;
endfunction

// E = -sum over i<j of J*si*sj
function automatic int model_energy(input logic [`ISING_N-1:0] s);
    int e;
    e = 0;
    for (int i = 0; i < `ISING_N; i++) begin
        for (int j = i + 1; j < `ISING_N; j++) begin
            e = (s[i] == s[j]) ? e - mw[i][j] : e + mw[i][j];
        end
    end
    return e;
endfunction

`endif

/* verif/tb_ising.sv */
// ====================
// Testbench for the spin solver top
// Clock, reset, random runs against the model
// Blocked writes, zero sweeps, zero couplings
// Four-phase handshake checks
// ====================
`timescale 1ns/100ps

`include "ising_config.svh"

module tb_ising;
    import ising_pkg::*;

    localparam int N          = `ISING_N;
    localparam int NP         = `ISING_NUM_PAIRS;
    localparam int WAIT_LIMIT = 200;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        wready;
    logic [31:0] wr_addr;
    logic [31:0] wdata;
    logic        res_ack;
    logic        res_req;
    result_t     res;
    spin_vec_t   spins;

    `include "ising_tb_model.svh"

    ising_top i_ising_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .wready  (wready),
        .wr_addr (wr_addr),
        .wdata   (wdata),
        .res_ack (res_ack),
        .res_req (res_req),
        .res     (res),
        .spins   (spins)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else
            report_failure($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        wready  = 1'b1;
        wr_addr = addr;
        wdata   = data;
        next_cycle();
        wready  = 1'b0;
    endtask

    // Triangular index of pair (i,j), i<j
    function automatic logic [31:0] weight_addr(input int i, input int j);
        return `ISING_WEIGHT_ADDR_BASE + 32'(4 * (N * i - i * (i + 1) / 2 + j - i - 1));
    endfunction

    task automatic set_weight(input int i, input int j, input weight_t w);
        mw[i][j] = int'(w);
        mw[j][i] = int'(w);
        write_word(weight_addr(i, j), {29'h0, w});
    endtask

    task automatic start_run(input spin_vec_t s, input sweep_t sw);
        write_word(`ISING_CTRL_ADDR, {16'h0, sw, s, 3'b000, 1'b1});
    endtask

    task automatic wait_result(input spin_vec_t exp_spins, input energy_t exp_energy,
                               input sweep_t exp_sweeps);
        int cnt;
        cnt = 0;
        while (res_req !== 1'b1 && cnt < WAIT_LIMIT) begin
            next_cycle();
            cnt++;
        end
        assert (res_req === 1'b1) else
            report_failure("Timed out waiting for res_req after a start write");
        check_hex("res.spins", 32'(res.spins), 32'(exp_spins));
        check_hex("res.energy", {24'h0, res.energy}, {24'h0, exp_energy});
        check_hex("res.sweeps", 32'(res.sweeps), 32'(exp_sweeps));
        // Live register holds the final spins while idle
        check_hex("spins", 32'(spins), 32'(exp_spins));
    endtask

    // Late ack, then a random hold of ack before release
    task automatic handshake();
        result_t held;
        int      delay;
        int      cnt;
        held  = res;
        delay = int'(rand_bits(3));
        for (int c = 0; c < delay; c++) begin
            next_cycle();
            check_hex("res_req", 32'(res_req), 32'h1);
            assert (res === held) else
                report_failure($sformatf("ERROR res changed before ack got 0x%0h expected 0x%0h",
                                         res, held));
        end
        res_ack = 1'b1;
        cnt     = 0;
        next_cycle();
        while (res_req !== 1'b0 && cnt < WAIT_LIMIT) begin
            next_cycle();
            cnt++;
        end
        assert (res_req === 1'b0) else
            report_failure("Timed out waiting for res_req to drop after res_ack");
        // No new request while ack is still high
        delay = int'(rand_bits(2));
        for (int c = 0; c < delay; c++) begin
            next_cycle();
            check_hex("res_req", 32'(res_req), 32'h0);
        end
        res_ack = 1'b0;
        repeat (2) begin
            next_cycle();
            check_hex("res_req", 32'(res_req), 32'h0);
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            next_cycle();
            check_hex("res_req", 32'(res_req), 32'h0);
        end
    endtask

    // Weight change, unmapped writes and a second start, all while busy
    task automatic blocked_writes(input spin_vec_t s);
        weight_t wb;
        wb = ~weight_t'(mw[0][1]);
        write_word(weight_addr(0, 1), {29'h0, wb});
        write_word(`ISING_WEIGHT_ADDR_BASE + 32'(4 * NP), rand_bits(32));
        write_word(32'h4, rand_bits(32));
        // Zero sweeps would load ~s at once
        start_run(~s, 8'd0);
    endtask

    task automatic random_run();
        spin_vec_t init;
        spin_vec_t exp_s;
        sweep_t    sw;
        for (int i = 0; i < N; i++) begin
            for (int j = i + 1; j < N; j++) begin
                set_weight(i, j, weight_t'(rand_bits(3)));
            end
        end
        init  = spin_vec_t'(rand_bits(N));
        sw    = sweep_t'(rand_bits(3)) + 8'd1;
        exp_s = model_run(init, int'(sw));
        start_run(init, sw);
        wait_result(exp_s, energy_t'(model_energy(exp_s)), sw);
        handshake();
    endtask

    initial begin
        spin_vec_t init;
        spin_vec_t exp_s;
        sweep_t    sw;
        lfsr    = 32'h3b30;
        rst_n   = 1'b0;
        wready  = 1'b0;
        wr_addr = '0;
        wdata   = '0;
        res_ack = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // State right after reset
        check_hex("res_req", 32'(res_req), 32'h0);
        check_hex("spins", 32'(spins), 32'h0);

        repeat (40) random_run();

        // Old weights must survive writes issued while busy
        init  = spin_vec_t'(rand_bits(N));
        sw    = 8'd3;
        exp_s = model_run(init, 3);
        start_run(init, sw);
        blocked_writes(init);
        wait_result(exp_s, energy_t'(model_energy(exp_s)), sw);
        blocked_writes(exp_s);
        check_hex("res_req", 32'(res_req), 32'h1);
        handshake();
        expect_quiet(30);
        // Refused start leaves the live spins alone
        check_hex("spins", 32'(spins), 32'(exp_s));

        // Zero sweeps
        init = spin_vec_t'(rand_bits(N));
        start_run(init, 8'd0);
        wait_result(init, energy_t'(model_energy(init)), 8'd0);
        handshake();

        // Zero couplings, spins frozen
        for (int i = 0; i < N; i++) begin
            for (int j = i + 1; j < N; j++) begin
                set_weight(i, j, '0);
            end
        end
        init = spin_vec_t'(rand_bits(N));
        sw   = sweep_t'(rand_bits(3)) + 8'd1;
        start_run(init, sw);
        wait_result(init, '0, sw);
        handshake();

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* tb.f */
+incdir+common
+incdir+verif
common/ising_pkg.sv
core/coupled_cell.sv
core/spin_cell.sv
core/core_matrix.sv
design/weight_regs.sv
design/readout.sv
design/ising_top.sv
verif/tb_ising.sv

/* run.sh */
#!/bin/sh
# Build and run the spin solver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_ising

status=0
out=$(./obj_dir/Vtb_ising) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
echo "Simulation failed (exit status $status)"
exit 1
